//--- logic/rob_types_pkg.sv
// reorder buffer datapath formats

package rob_types_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    // data and pc words
    localparam int XLEN = 32;
    // architectural register index
    localparam int REG_IDX_W = 5;
    localparam int NUM_ARCH_REGS = 32;

    typedef logic [XLEN-1:0] xlen_word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // x0, hardwired zero
    localparam reg_idx_t ZERO_REG = '0;

    ////////////////////////////////////////////////////////////
    // one reorder buffer entry
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        // slot holds a dispatched instruction
        logic       valid;
        // result has arrived on the cdb
        logic       ready;
        xlen_word_t pc;
        reg_idx_t   dest;
        logic       is_branch;
        // direction fetch assumed
        logic       pred_taken;
        // actual direction differs from prediction
        logic       mispred;
        // result, or branch target for a branch
        xlen_word_t value;
    } rob_entry_t;

endpackage

//--- logic/rob_ctrl_pkg.sv
// reorder buffer control definitions

package rob_ctrl_pkg;

    // recovery states
    // run is normal dispatch and retire
    // flush is the single squash cycle after a mispredict retires
    typedef enum logic {
        RUN   = 1'b0,
        FLUSH = 1'b1
    } recovery_state_t;

    // byte length of one instruction
    localparam int PC_STEP = 4;

    // entries when the top level is left at its default
    localparam int DEFAULT_ROB_DEPTH = 8;

endpackage

//--- logic/rob_pointers.sv
// reorder buffer head and tail pointers

`timescale 1ns/1ps

module rob_pointers #(
    parameter int ROB_DEPTH = rob_ctrl_pkg::DEFAULT_ROB_DEPTH,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             push,
    input  logic             pop,
    input  logic             clear,
    output logic [TAG_W-1:0] head,
    output logic [TAG_W-1:0] tail,
    output logic             full,
    output logic             empty
);

    // one bit wider than a tag so full is distinct from empty
    logic [TAG_W:0] count;

    ////////////////////////////////////////////////////////////
    // index and occupancy update
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || clear) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // depth is a power of two, so plain increment wraps
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            // push and pop together leave occupancy unchanged
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // status flags
    assign full  = (count == (TAG_W + 1)'(ROB_DEPTH));
    assign empty = (count == '0);

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // dispatch must respect back-pressure
    push_not_full_a : assert property (
        @(posedge clock) disable iff (reset)
        push |-> !full
    );

    // retire only from an occupied buffer
    pop_not_empty_a : assert property (
        @(posedge clock) disable iff (reset)
        pop |-> !empty
    );

endmodule

//--- logic/rob_entries.sv
// reorder buffer entry storage

`timescale 1ns/1ps

module rob_entries #(
    parameter int ROB_DEPTH = rob_ctrl_pkg::DEFAULT_ROB_DEPTH,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      clear,

    // dispatch into the tail slot
    input  logic                      push,
    input  rob_types_pkg::xlen_word_t dispatch_pc,
    input  rob_types_pkg::reg_idx_t   dispatch_dest,
    input  logic                      dispatch_is_branch,
    input  logic                      dispatch_pred_taken,

    // retire from the head slot
    input  logic                      pop,
    input  logic [TAG_W-1:0]          head,
    input  logic [TAG_W-1:0]          tail,

    // common data bus
    input  logic                      cdb_valid,
    input  logic [TAG_W-1:0]          cdb_tag,
    input  rob_types_pkg::xlen_word_t cdb_value,
    input  logic                      cdb_taken,

    // operand forwarding
    input  logic [TAG_W-1:0]          src_tag_a,
    input  logic [TAG_W-1:0]          src_tag_b,
    output rob_types_pkg::xlen_word_t src_value_a,
    output rob_types_pkg::xlen_word_t src_value_b,

    // head view
    output logic                      head_ready,
    output logic                      head_mispred,
    output rob_types_pkg::reg_idx_t   head_dest,
    output rob_types_pkg::xlen_word_t head_value,
    output rob_types_pkg::xlen_word_t head_redirect_pc
);

    import rob_types_pkg::*;
    import rob_ctrl_pkg::*;

    rob_entry_t entries [ROB_DEPTH];

    // entry the cdb is completing
    rob_entry_t cdb_entry;
    // entry at the head
    rob_entry_t head_entry;

    assign cdb_entry  = entries[cdb_tag];
    assign head_entry = entries[head];

    ////////////////////////////////////////////////////////////
    // entry updates
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || clear) begin
            // only the status bits, payload is dead once invalid
            for (int i = 0; i < ROB_DEPTH; i++) begin
                entries[i].valid   <= 1'b0;
                entries[i].ready   <= 1'b0;
                entries[i].mispred <= 1'b0;
            end
        end else begin
            // new instruction, result still pending
            if (push) begin
                entries[tail] <= '{
                    valid:      1'b1,
                    ready:      1'b0,
                    pc:         dispatch_pc,
                    dest:       dispatch_dest,
                    is_branch:  dispatch_is_branch,
                    pred_taken: dispatch_pred_taken,
                    mispred:    1'b0,
                    value:      '0
                };
            end
            // completion, direction compared against prediction
            if (cdb_valid) begin
                entries[cdb_tag].ready   <= 1'b1;
                entries[cdb_tag].value   <= cdb_value;
                entries[cdb_tag].mispred <= cdb_entry.is_branch &&
                                            (cdb_taken != cdb_entry.pred_taken);
            end
            // retired slot frees up
            if (pop) begin
                entries[head].valid   <= 1'b0;
                entries[head].ready   <= 1'b0;
                entries[head].mispred <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // read ports
    ////////////////////////////////////////////////////////////

    // source operands by tag, zero until completed
    assign src_value_a = entries[src_tag_a].value;
    assign src_value_b = entries[src_tag_b].value;

    assign head_ready   = head_entry.valid && head_entry.ready;
    assign head_mispred = head_entry.mispred;
    assign head_dest    = head_entry.dest;
    assign head_value   = head_entry.value;

    // predicted taken means the fall-through was skipped
    // otherwise the stored target is the missed path
    assign head_redirect_pc = head_entry.pred_taken ?
                              (head_entry.pc + xlen_word_t'(PC_STEP)) :
                              head_entry.value;

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // cdb may only complete a dispatched instruction
    cdb_tag_valid_a : assert property (
        @(posedge clock) disable iff (reset)
        cdb_valid |-> cdb_entry.valid
    );

endmodule

//--- logic/rob_recovery_fsm.sv
// reorder buffer recovery control

`timescale 1ns/1ps

module rob_recovery_fsm (
    input  logic                      clock,
    input  logic                      reset,

    // buffer status
    input  logic                      dispatch_valid,
    input  logic                      full,
    input  logic                      empty,
    input  logic                      head_ready,
    input  logic                      head_mispred,
    input  rob_types_pkg::xlen_word_t head_redirect_pc,

    // grants
    output logic                      dispatch_ready,
    output logic                      push,
    output logic                      pop,

    // recovery
    output logic                      squash,
    output rob_types_pkg::xlen_word_t redirect_pc
);

    import rob_ctrl_pkg::*;

    recovery_state_t state;
    recovery_state_t state_next;

    // head retires with a wrong prediction
    logic mispred_pop;

    ////////////////////////////////////////////////////////////
    // grants
    ////////////////////////////////////////////////////////////

    // no dispatch into a full buffer even if the head retires now
    assign dispatch_ready = (state == RUN) && !full;
    assign push           = dispatch_valid && dispatch_ready;

    // in-order retire of one entry per cycle
    assign pop         = (state == RUN) && !empty && head_ready;
    assign mispred_pop = pop && head_mispred;

    // single flush cycle
    assign squash = (state == FLUSH);

    ////////////////////////////////////////////////////////////
    // state
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            RUN: begin
                if (mispred_pop) begin
                    state_next = FLUSH;
                end
            end
            // buffer clears at the end of this cycle
            FLUSH: state_next = RUN;
            default: state_next = RUN;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= RUN;
        end else begin
            state <= state_next;
        end
    end

    // redirect target held for the flush cycle
    always_ff @(posedge clock) begin
        if (mispred_pop) begin
            redirect_pc <= head_redirect_pc;
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // buffer is empty once the flush cycle ends
    flush_clears_buffer_a : assert property (
        @(posedge clock) disable iff (reset)
        squash |=> empty
    );

endmodule

//--- logic/arch_regfile.sv
// architectural register file

`timescale 1ns/1ps

module arch_regfile (
    input  logic                      clock,
    input  logic                      reset,

    // retire write
    input  logic                      write_enable,
    input  rob_types_pkg::reg_idx_t   write_dest,
    input  rob_types_pkg::xlen_word_t write_value,

    // committed state read
    input  rob_types_pkg::reg_idx_t   read_idx,
    output rob_types_pkg::xlen_word_t read_value
);

    import rob_types_pkg::*;

    xlen_word_t regs [NUM_ARCH_REGS];

    // committed state starts at zero
    // x0 is never written, so it stays zero
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && (write_dest != ZERO_REG)) begin
            regs[write_dest] <= write_value;
        end
    end

    // new value visible after the retire edge
    assign read_value = regs[read_idx];

endmodule

//--- logic/rob_top.sv
// reorder buffer commit top level

`timescale 1ns/1ps

module rob_top #(
    parameter int ROB_DEPTH = rob_ctrl_pkg::DEFAULT_ROB_DEPTH,
    localparam int TAG_W = $clog2(ROB_DEPTH)
) (
    input  logic                      clock,
    input  logic                      reset,

    // dispatch
    input  logic                      dispatch_valid,
    input  rob_types_pkg::xlen_word_t dispatch_pc,
    input  rob_types_pkg::reg_idx_t   dispatch_dest,
    input  logic                      dispatch_is_branch,
    input  logic                      dispatch_pred_taken,
    output logic                      dispatch_ready,
    output logic [TAG_W-1:0]          dispatch_tag,

    // common data bus
    input  logic                      cdb_valid,
    input  logic [TAG_W-1:0]          cdb_tag,
    input  rob_types_pkg::xlen_word_t cdb_value,
    input  logic                      cdb_taken,

    // operand read
    input  logic [TAG_W-1:0]          src_tag_a,
    input  logic [TAG_W-1:0]          src_tag_b,
    output rob_types_pkg::xlen_word_t src_value_a,
    output rob_types_pkg::xlen_word_t src_value_b,

    // retire
    output logic                      retire_valid,
    output rob_types_pkg::reg_idx_t   retire_dest,
    output rob_types_pkg::xlen_word_t retire_value,

    // recovery
    output logic                      squash,
    output rob_types_pkg::xlen_word_t redirect_pc,

    // committed state
    input  rob_types_pkg::reg_idx_t   arch_read_idx,
    output rob_types_pkg::xlen_word_t arch_read_value
);

    import rob_types_pkg::*;

    ////////////////////////////////////////////////////////////
    // internal wires
    ////////////////////////////////////////////////////////////

    logic             push;
    logic             pop;
    logic [TAG_W-1:0] head;
    logic [TAG_W-1:0] tail;
    logic             full;
    logic             empty;

    logic             head_ready;
    logic             head_mispred;
    reg_idx_t         head_dest;
    xlen_word_t       head_value;
    xlen_word_t       head_redirect_pc;

    // next free slot is the new instruction's tag
    assign dispatch_tag = tail;

    // retire is the head pop
    assign retire_valid = pop;
    assign retire_dest  = head_dest;
    assign retire_value = head_value;

    ////////////////////////////////////////////////////////////
    // blocks
    ////////////////////////////////////////////////////////////

    rob_pointers #(
        .ROB_DEPTH (ROB_DEPTH)
    ) pointers_i (
        .clock (clock),
        .reset (reset),
        .push  (push),
        .pop   (pop),
        .clear (squash),
        .head  (head),
        .tail  (tail),
        .full  (full),
        .empty (empty)
    );

    rob_entries #(
        .ROB_DEPTH (ROB_DEPTH)
    ) entries_i (
        .clock               (clock),
        .reset               (reset),
        .clear               (squash),
        .push                (push),
        .dispatch_pc         (dispatch_pc),
        .dispatch_dest       (dispatch_dest),
        .dispatch_is_branch  (dispatch_is_branch),
        .dispatch_pred_taken (dispatch_pred_taken),
        .pop                 (pop),
        .head                (head),
        .tail                (tail),
        .cdb_valid           (cdb_valid),
        .cdb_tag             (cdb_tag),
        .cdb_value           (cdb_value),
        .cdb_taken           (cdb_taken),
        .src_tag_a           (src_tag_a),
        .src_tag_b           (src_tag_b),
        .src_value_a         (src_value_a),
        .src_value_b         (src_value_b),
        .head_ready          (head_ready),
        .head_mispred        (head_mispred),
        .head_dest           (head_dest),
        .head_value          (head_value),
        .head_redirect_pc    (head_redirect_pc)
    );

    rob_recovery_fsm recovery_i (
        .clock            (clock),
        .reset            (reset),
        .dispatch_valid   (dispatch_valid),
        .full             (full),
        .empty            (empty),
        .head_ready       (head_ready),
        .head_mispred     (head_mispred),
        .head_redirect_pc (head_redirect_pc),
        .dispatch_ready   (dispatch_ready),
        .push             (push),
        .pop              (pop),
        .squash           (squash),
        .redirect_pc      (redirect_pc)
    );

    // written at the retire edge
    arch_regfile regfile_i (
        .clock        (clock),
        .reset        (reset),
        .write_enable (pop),
        .write_dest   (head_dest),
        .write_value  (head_value),
        .read_idx     (arch_read_idx),
        .read_value   (arch_read_value)
    );

endmodule

//--- verif/rob_tb.sv
// reorder buffer testbench

`timescale 1ns/1ps

module rob_tb;

    import rob_types_pkg::*;
    import rob_ctrl_pkg::*;

    localparam int DEPTH = DEFAULT_ROB_DEPTH;
    localparam int TAG_W = $clog2(DEPTH);
    // longest any wait may take, in cycles
    localparam int WAIT_LIMIT = 40;

    typedef logic [TAG_W-1:0] tag_t;

    // what a row does in its cycle
    typedef enum logic [2:0] {
        OP_IDLE, OP_DISP, OP_CPL, OP_DISP_CPL, OP_DRAIN, OP_SQUASH
    } op_t;

    // retire expected in the row's cycle
    typedef enum logic [1:0] {
        EXP_MODEL, EXP_NONE, EXP_RETIRE
    } retire_check_t;

    typedef struct packed {
        op_t           op;
        xlen_word_t    pc;
        reg_idx_t      dest;
        logic          is_branch;
        logic          pred_taken;
        tag_t          cdb_tag;
        xlen_word_t    cdb_value;
        logic          cdb_taken;
        retire_check_t retire_check;
        reg_idx_t      exp_dest;
        xlen_word_t    exp_value;
    } row_t;

    // model copy of one buffered instruction
    typedef struct packed {
        tag_t       tag;
        reg_idx_t   dest;
        xlen_word_t pc;
        logic       is_branch;
        logic       pred_taken;
        logic       ready;
        logic       mispred;
        xlen_word_t value;
    } inflight_t;

    logic       clock;
    logic       reset;
    logic       dispatch_valid;
    xlen_word_t dispatch_pc;
    reg_idx_t   dispatch_dest;
    logic       dispatch_is_branch;
    logic       dispatch_pred_taken;
    logic       dispatch_ready;
    tag_t       dispatch_tag;
    logic       cdb_valid;
    tag_t       cdb_tag;
    xlen_word_t cdb_value;
    logic       cdb_taken;
    tag_t       src_tag_a;
    tag_t       src_tag_b;
    xlen_word_t src_value_a;
    xlen_word_t src_value_b;
    logic       retire_valid;
    reg_idx_t   retire_dest;
    xlen_word_t retire_value;
    logic       squash;
    xlen_word_t redirect_pc;
    reg_idx_t   arch_read_idx;
    xlen_word_t arch_read_value;

    ////////////////////////////////////////////////////////////
    // reference model state
    ////////////////////////////////////////////////////////////

    inflight_t  pending [$];
    xlen_word_t arch_model [NUM_ARCH_REGS];
    tag_t       next_tag;
    logic       flush_due;
    xlen_word_t redirect_model;
    reg_idx_t   last_dest;
    row_t       table_rows [$];
    logic       seen_retire;
    logic       seen_squash;
    int         errors;
    int         timeouts;
    logic       aborted;

    rob_top #(
        .ROB_DEPTH (DEPTH)
    ) dut_i (
        .clock               (clock),
        .reset               (reset),
        .dispatch_valid      (dispatch_valid),
        .dispatch_pc         (dispatch_pc),
        .dispatch_dest       (dispatch_dest),
        .dispatch_is_branch  (dispatch_is_branch),
        .dispatch_pred_taken (dispatch_pred_taken),
        .dispatch_ready      (dispatch_ready),
        .dispatch_tag        (dispatch_tag),
        .cdb_valid           (cdb_valid),
        .cdb_tag             (cdb_tag),
        .cdb_value           (cdb_value),
        .cdb_taken           (cdb_taken),
        .src_tag_a           (src_tag_a),
        .src_tag_b           (src_tag_b),
        .src_value_a         (src_value_a),
        .src_value_b         (src_value_b),
        .retire_valid        (retire_valid),
        .retire_dest         (retire_dest),
        .retire_value        (retire_value),
        .squash              (squash),
        .redirect_pc         (redirect_pc),
        .arch_read_idx       (arch_read_idx),
        .arch_read_value     (arch_read_value)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            errors++;
            $display("[ERROR] %s: got %h expected %h", name, got, expected);
        end
    endtask

    task automatic append_row(input op_t op, input int pc, input int dest, input int br,
                              input int pt, input int tag, input int value, input int taken,
                              input retire_check_t chk, input int edest, input int evalue);
        row_t r;
        r.op           = op;
        r.pc           = xlen_word_t'(pc);
        r.dest         = reg_idx_t'(dest);
        r.is_branch    = 1'(br);
        r.pred_taken   = 1'(pt);
        r.cdb_tag      = tag_t'(tag);
        r.cdb_value    = xlen_word_t'(value);
        r.cdb_taken    = 1'(taken);
        r.retire_check = chk;
        r.exp_dest     = reg_idx_t'(edest);
        r.exp_value    = xlen_word_t'(evalue);
        table_rows.push_back(r);
    endtask

    ////////////////////////////////////////////////////////////
    // model update at the edge that ends a cycle
    ////////////////////////////////////////////////////////////

    task automatic update_model(input row_t r, input logic exp_retire, input logic exp_ready);
        inflight_t head;
        inflight_t entry;
        int        hit;
        if (flush_due) begin
            // everything younger than the branch is gone
            pending.delete();
            next_tag  = '0;
            flush_due = 1'b0;
            return;
        end
        if (exp_retire) begin
            head = pending.pop_front();
            // x0 keeps its zero
            if (head.dest != ZERO_REG) begin
                arch_model[head.dest] = head.value;
            end
            last_dest = head.dest;
            if (head.mispred) begin
                flush_due = 1'b1;
                // predicted taken means the fall-through was skipped
                if (head.pred_taken) begin
                    redirect_model = head.pc + xlen_word_t'(PC_STEP);
                end else begin
                    redirect_model = head.value;
                end
            end
        end
        if (r.op == OP_CPL || r.op == OP_DISP_CPL) begin
            hit = -1;
            for (int i = 0; i < pending.size(); i++) begin
                if (pending[i].tag == r.cdb_tag) begin
                    hit = i;
                end
            end
            assert (hit >= 0) else begin
                errors++;
                $display("cdb tag %0d does not name a pending instruction", r.cdb_tag);
            end
            if (hit >= 0) begin
                entry         = pending[hit];
                entry.ready   = 1'b1;
                entry.value   = r.cdb_value;
                entry.mispred = entry.is_branch && (r.cdb_taken != entry.pred_taken);
                pending[hit]  = entry;
            end
        end
        // refused while full or flushing
        if ((r.op == OP_DISP || r.op == OP_DISP_CPL) && exp_ready) begin
            entry = '{tag: next_tag, dest: r.dest, pc: r.pc, is_branch: r.is_branch,
                      pred_taken: r.pred_taken, ready: 1'b0, mispred: 1'b0, value: '0};
            pending.push_back(entry);
            next_tag = next_tag + 1'b1;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // one clock cycle: drive, sample, check
    ////////////////////////////////////////////////////////////

    task automatic run_cycle(input row_t r);
        int   ia;
        int   ib;
        logic exp_retire;
        logic exp_ready;
        @(posedge clock);
        #1;
        dispatch_valid      = (r.op == OP_DISP) || (r.op == OP_DISP_CPL);
        dispatch_pc         = r.pc;
        dispatch_dest       = r.dest;
        dispatch_is_branch  = r.is_branch;
        dispatch_pred_taken = r.pred_taken;
        cdb_valid           = (r.op == OP_CPL) || (r.op == OP_DISP_CPL);
        cdb_tag             = r.cdb_tag;
        cdb_value           = r.cdb_value;
        cdb_taken           = r.cdb_taken;
        arch_read_idx       = last_dest;
        // oldest and youngest completed entries on the operand ports
        ia = -1;
        ib = -1;
        for (int i = 0; i < pending.size(); i++) begin
            if (pending[i].ready) begin
                if (ia < 0) begin
                    ia = i;
                end
                ib = i;
            end
        end
        src_tag_a = (ia >= 0) ? pending[ia].tag : '0;
        src_tag_b = (ib >= 0) ? pending[ib].tag : '0;
        // outputs settled, next edge still 1 ns away
        #2;
        exp_retire  = !flush_due && (pending.size() > 0) && pending[0].ready;
        exp_ready   = !flush_due && (pending.size() < DEPTH);
        seen_retire = retire_valid;
        seen_squash = squash;
        check_value("retire_valid", 32'(retire_valid), 32'(exp_retire));
        check_value("dispatch_ready", 32'(dispatch_ready), 32'(exp_ready));
        check_value("squash", 32'(squash), 32'(flush_due));
        if (flush_due) begin
            check_value("redirect_pc", redirect_pc, redirect_model);
        end
        if (exp_ready) begin
            check_value("dispatch_tag", 32'(dispatch_tag), 32'(next_tag));
        end
        if (exp_retire) begin
            check_value("retire_dest", 32'(retire_dest), 32'(pending[0].dest));
            check_value("retire_value", retire_value, pending[0].value);
        end
        // fixed expectations from the table
        if (r.retire_check == EXP_NONE) begin
            check_value("retire_valid", 32'(retire_valid), 32'd0);
        end else if (r.retire_check == EXP_RETIRE) begin
            check_value("retire_valid", 32'(retire_valid), 32'd1);
            check_value("retire_dest", 32'(retire_dest), 32'(r.exp_dest));
            check_value("retire_value", retire_value, r.exp_value);
        end
        check_value("arch_read_value", arch_read_value, arch_model[arch_read_idx]);
        if (ia >= 0) begin
            check_value("src_value_a", src_value_a, pending[ia].value);
        end
        if (ib >= 0) begin
            check_value("src_value_b", src_value_b, pending[ib].value);
        end
        update_model(r, exp_retire, exp_ready);
    endtask

    // idle until nothing is left to retire
    task automatic wait_drained();
        row_t idle_row;
        int   cycles;
        idle_row = '0;
        cycles   = 0;
        while ((pending.size() != 0 || seen_retire) && cycles < WAIT_LIMIT) begin
            run_cycle(idle_row);
            cycles++;
        end
        if (pending.size() != 0 || seen_retire) begin
            timeouts++;
            aborted = 1'b1;
            $display("timeout: buffer still retiring after %0d cycles", WAIT_LIMIT);
        end
    endtask

    // idle until the flush pulse
    task automatic wait_squash();
        row_t idle_row;
        int   cycles;
        idle_row    = '0;
        cycles      = 0;
        seen_squash = 1'b0;
        while (!seen_squash && cycles < WAIT_LIMIT) begin
            run_cycle(idle_row);
            cycles++;
        end
        if (!seen_squash) begin
            timeouts++;
            aborted = 1'b1;
            $display("timeout: no squash within %0d cycles", WAIT_LIMIT);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////

    task automatic build_table();
        int order [8] = '{7, 5, 4, 6, 3, 1, 0, 2};
        // completed out of order, retired in order
        append_row(OP_DISP, 'h100, 1, 0, 0, 0, 0, 0, EXP_NONE, 0, 0);
        append_row(OP_DISP, 'h104, 2, 0, 0, 0, 0, 0, EXP_NONE, 0, 0);
        append_row(OP_DISP, 'h108, 3, 0, 0, 0, 0, 0, EXP_NONE, 0, 0);
        append_row(OP_CPL, 0, 0, 0, 0, 2, 'h3333_0003, 0, EXP_NONE, 0, 0);
        append_row(OP_CPL, 0, 0, 0, 0, 1, 'h2222_0002, 0, EXP_NONE, 0, 0);
        append_row(OP_CPL, 0, 0, 0, 0, 0, 'h1111_0001, 0, EXP_NONE, 0, 0);
        append_row(OP_IDLE, 0, 0, 0, 0, 0, 0, 0, EXP_RETIRE, 1, 'h1111_0001);
        append_row(OP_IDLE, 0, 0, 0, 0, 0, 0, 0, EXP_RETIRE, 2, 'h2222_0002);
        append_row(OP_IDLE, 0, 0, 0, 0, 0, 0, 0, EXP_RETIRE, 3, 'h3333_0003);
        // retire into x0
        append_row(OP_DISP, 'h10c, 0, 0, 0, 0, 0, 0, EXP_NONE, 0, 0);
        append_row(OP_CPL, 0, 0, 0, 0, 3, 'hdead_beef, 0, EXP_NONE, 0, 0);
        append_row(OP_IDLE, 0, 0, 0, 0, 0, 0, 0, EXP_RETIRE, 0, 'hdead_beef);
        append_row(OP_IDLE, 0, 0, 0, 0, 0, 0, 0, EXP_NONE, 0, 0);
        // fill, one refused dispatch, then drain
        for (int i = 0; i < DEPTH; i++) begin
            append_row(OP_DISP, 'h180 + 4 * i, 4 + i, 0, 0, 0, 0, 0, EXP_MODEL, 0, 0);
        end
        append_row(OP_DISP, 'h1f0, 20, 0, 0, 0, 0, 0, EXP_NONE, 0, 0);
        foreach (order[i]) begin
            append_row(OP_CPL, 0, 0, 0, 0, order[i], int'($urandom), 0, EXP_MODEL, 0, 0);
        end
        append_row(OP_DRAIN, 0, 0, 0, 0, 0, 0, 0, EXP_MODEL, 0, 0);
        // predicted taken, actually not taken
        append_row(OP_DISP, 'h200, 5, 1, 1, 0, 0, 0, EXP_MODEL, 0, 0);
        append_row(OP_DISP, 'h204, 6, 0, 0, 0, 0, 0, EXP_MODEL, 0, 0);
        append_row(OP_DISP, 'h208, 7, 0, 0, 0, 0, 0, EXP_MODEL, 0, 0);
        append_row(OP_CPL, 0, 0, 0, 0, 5, int'($urandom), 0, EXP_MODEL, 0, 0);
        append_row(OP_CPL, 0, 0, 0, 0, 6, int'($urandom), 0, EXP_MODEL, 0, 0);
        append_row(OP_CPL, 0, 0, 0, 0, 4, 'h300, 0, EXP_MODEL, 0, 0);
        append_row(OP_SQUASH, 0, 0, 0, 0, 0, 0, 0, EXP_MODEL, 0, 0);
        // predicted not taken, actually taken
        append_row(OP_DISP, 'h400, 8, 1, 0, 0, 0, 0, EXP_MODEL, 0, 0);
        append_row(OP_DISP, 'h404, 9, 0, 0, 0, 0, 0, EXP_MODEL, 0, 0);
        append_row(OP_CPL, 0, 0, 0, 0, 1, int'($urandom), 0, EXP_MODEL, 0, 0);
        append_row(OP_CPL, 0, 0, 0, 0, 0, 'h480, 1, EXP_MODEL, 0, 0);
        append_row(OP_SQUASH, 0, 0, 0, 0, 0, 0, 0, EXP_MODEL, 0, 0);
        // correct prediction retires without a flush
        append_row(OP_DISP, 'h500, 10, 1, 1, 0, 0, 0, EXP_MODEL, 0, 0);
        append_row(OP_DISP, 'h504, 11, 0, 0, 0, 0, 0, EXP_MODEL, 0, 0);
        append_row(OP_DISP_CPL, 'h508, 12, 0, 0, 0, 'h600, 1, EXP_MODEL, 0, 0);
        append_row(OP_CPL, 0, 0, 0, 0, 1, int'($urandom), 0, EXP_MODEL, 0, 0);
        append_row(OP_CPL, 0, 0, 0, 0, 2, int'($urandom), 0, EXP_MODEL, 0, 0);
        append_row(OP_DRAIN, 0, 0, 0, 0, 0, 0, 0, EXP_MODEL, 0, 0);
    endtask

    initial begin
        void'($urandom(32'hc247_ed45));
        errors              = 0;
        timeouts            = 0;
        aborted             = 1'b0;
        seen_retire         = 1'b0;
        seen_squash         = 1'b0;
        next_tag            = '0;
        flush_due           = 1'b0;
        redirect_model      = '0;
        last_dest           = '0;
        foreach (arch_model[i]) begin
            arch_model[i] = '0;
        end
        dispatch_valid      = 1'b0;
        dispatch_pc         = '0;
        dispatch_dest       = '0;
        dispatch_is_branch  = 1'b0;
        dispatch_pred_taken = 1'b0;
        cdb_valid           = 1'b0;
        cdb_tag             = '0;
        cdb_value           = '0;
        cdb_taken           = 1'b0;
        src_tag_a           = '0;
        src_tag_b           = '0;
        arch_read_idx       = '0;
        reset               = 1'b1;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
        build_table();
        for (int i = 0; i < table_rows.size() && !aborted; i++) begin
            case (table_rows[i].op)
                OP_DRAIN:  wait_drained();
                OP_SQUASH: wait_squash();
                default:   run_cycle(table_rows[i]);
            endcase
        end
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- compile.f
logic/rob_types_pkg.sv
logic/rob_ctrl_pkg.sv
logic/rob_pointers.sv
logic/rob_entries.sv
logic/rob_recovery_fsm.sv
logic/arch_regfile.sv
logic/rob_top.sv
verif/rob_tb.sv

//--- Makefile
# Verilator build and run of the reorder buffer testbench

SOURCES := $(shell grep -v '^+' compile.f)

obj_dir/Vrob_tb: compile.f $(SOURCES)
	verilator --binary --timing --assert --top-module rob_tb -f compile.f -Mdir obj_dir -o Vrob_tb

run: obj_dir/Vrob_tb
	obj_dir/Vrob_tb > sim.log 2>&1; cat sim.log
	@if grep -q "Something failed" sim.log; then exit 1; fi
	@grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
